/* core.f */
common/core_pkg.sv
verilog/alu.sv
verilog/registers.sv
verilog/program_counter.sv
control/control.sv
verilog/core.sv
bench/core_tb.sv

/* Bender.yml */
package:
  name: core

sources:
  - common/core_pkg.sv
  - verilog/alu.sv
  - verilog/registers.sv
  - verilog/program_counter.sv
  - control/control.sv
  - verilog/core.sv
  - target: simulation
    files:
      - bench/core_tb.sv

/* bench/core_tb.sv */
`timescale 1ns/1ps

module core_tb;

  logic        CLK;
  logic        rst_n;
  logic [31:0] DMEM_ARADDR, DMEM_AWADDR, DMEM_WDATA, DMEM_RDATA;
  logic        DMEM_AWVALID;
  logic [31:0] IMEM_ARADDR, IMEM_RDATA;
  logic        halted;

  // 1 KB word indexed memories
  logic [31:0] imem [0:255];
  logic [31:0] dmem [0:255];
  logic [31:0] exp_mem [0:255];
  // Expected store stream with the address in the upper word
  logic [63:0] exp_st [$];
  int          st_idx, exp_count, plen, errors, pass_cnt, fail_cnt;
  logic        checking;
  logic [31:0] rng;
  longint      budget_ns;

  core dut (.*);

  // Both memories answer in the same cycle
  assign IMEM_RDATA = imem[IMEM_ARADDR[9:2]];
  assign DMEM_RDATA = dmem[DMEM_ARADDR[9:2]];

  always @(posedge CLK) begin
    if (DMEM_AWVALID) begin
      dmem[DMEM_AWADDR[9:2]] <= DMEM_WDATA;
    end
  end

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // Instruction encoders
  function automatic logic [31:0] alu_r(input logic [2:0] f3, input logic [4:0] rd, rs1, rs2,
                                        input logic sub);
    return {sub ? 7'b0100000 : 7'b0, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] alu_i(input logic [2:0] f3, input logic [4:0] rd, rs1,
                                        input logic [31:0] imm);
    return {imm[11:0], rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] lw_op(input logic [4:0] rd, rs1, input logic [31:0] imm);
    return {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
  endfunction

  function automatic logic [31:0] sw_op(input logic [4:0] rs2, rs1, input logic [31:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] br_op(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                        input logic [31:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jal_op(input logic [4:0] rd, input logic [31:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] lui_op(input logic [4:0] rd, input logic [31:0] imm);
    return {imm[31:12], rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] ebreak_op();
    return {12'd1, 13'd0, 7'b1110011};
  endfunction

  // ALU funct3 picks where SUB shares 000
  function automatic logic [2:0] funct3_for(input logic [2:0] s);
    case (s)
      3'd2, 3'd7: return 3'b010;
      3'd3: return 3'b100;
      3'd4: return 3'b110;
      3'd5: return 3'b111;
      default: return 3'b000;
    endcase
  endfunction

  task automatic emit(input logic [31:0] instr);
    imem[plen] = instr;
    plen++;
  endtask

  task automatic new_program();
    for (int i = 0; i < 256; i++) imem[i] = ebreak_op();
    plen = 0;
  endtask

  // LUI rounds up so ADDI can add a negative low part
  task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
    emit(lui_op(rd, value + 32'h800));
    emit(alu_i(3'b000, rd, rd, value));
  endtask

  task automatic fill_dmem();
    for (int i = 0; i < 256; i++) dmem[i] = (32'(i) * 32'h9E37_79B9) ^ 32'h5A5A_0000;
  endtask

  // Behavioral RV32I subset that runs from the loaded imem and dmem
  function automatic void run_ref();
    logic [31:0] r [0:31];
    logic [31:0] pc, pc_next, ins, a, b, addr, wval;
    logic [2:0]  f3;
    logic        wen, done, is_imm;
    for (int i = 0; i < 32; i++) r[i] = '0;
    for (int i = 0; i < 256; i++) exp_mem[i] = dmem[i];
    exp_st.delete();
    pc = 0;
    exp_count = 0;
    done = 1'b0;
    while (!done && exp_count < 1000) begin
      ins = imem[pc[9:2]];
      f3 = ins[14:12];
      a = r[ins[19:15]];
      b = r[ins[24:20]];
      wen = 1'b0;
      wval = '0;
      pc_next = pc + 4;
      exp_count++;
      case (ins[6:0])
        7'b0110011, 7'b0010011: begin
          is_imm = (ins[6:0] == 7'b0010011);
          if (is_imm) b = {{20{ins[31]}}, ins[31:20]};
          wen = 1'b1;
          if (!is_imm && ins[31:25] == 7'b0100000 && f3 == 3'b000) begin
            wval = a - b;
          end else if (!is_imm && ins[31:25] != 7'b0) begin
            wen = 1'b0;
          end else begin
            case (f3)
              3'b000: wval = a + b;
              3'b010: wval = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
              3'b100: wval = a ^ b;
              3'b110: wval = a | b;
              3'b111: wval = a & b;
              default: wen = 1'b0;
            endcase
          end
        end
        7'b0110111: begin
          wen = 1'b1;
          wval = {ins[31:12], 12'b0};
        end
        7'b0000011: begin
          addr = a + {{20{ins[31]}}, ins[31:20]};
          wen = (f3 == 3'b010);
          wval = exp_mem[addr[9:2]];
        end
        7'b0100011: begin
          addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
          if (f3 == 3'b010) begin
            exp_mem[addr[9:2]] = b;
            exp_st.push_back({addr, b});
          end
        end
        7'b1100011: begin
          if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b))
            pc_next = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        end
        7'b1101111: begin
          wen = 1'b1;
          wval = pc + 4;
          pc_next = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        end
        default: done = (ins == ebreak_op());
      endcase
      if (wen && ins[11:7] != 5'd0) r[ins[11:7]] = wval;
      pc = pc_next;
    end
  endfunction

  // Store checker takes one entry per strobe
  always @(posedge CLK) begin
    if (checking && DMEM_AWVALID) begin
      assert (st_idx < exp_st.size()) else begin
        $display("unexpected store to %h beyond the expected sequence", DMEM_AWADDR);
        errors++;
      end
      if (st_idx < exp_st.size()) begin
        assert (DMEM_AWADDR == exp_st[st_idx][63:32]) else begin
          $display("mismatch DMEM_AWADDR store %0d: expected %h actual %h",
                   st_idx, exp_st[st_idx][63:32], DMEM_AWADDR);
          errors++;
        end
        assert (DMEM_WDATA == exp_st[st_idx][31:0]) else begin
          $display("mismatch DMEM_WDATA store %0d: expected %h actual %h",
                   st_idx, exp_st[st_idx][31:0], DMEM_WDATA);
          errors++;
        end
      end
      st_idx++;
    end
  end

  // Entered 2 ns after an edge
  task automatic apply_reset();
    rst_n = 1'b0;
    #1;
    assert (!DMEM_AWVALID) else begin
      $display("store strobe high as reset asserts");
      errors++;
    end
    repeat (10) begin
      @(posedge CLK);
      #1;
      assert (!DMEM_AWVALID) else begin
        $display("store strobe high during reset");
        errors++;
      end
    end
    #1 rst_n = 1'b1;
    #1;
    assert (IMEM_ARADDR == 32'h0) else begin
      $display("mismatch IMEM_ARADDR after reset: expected %h actual %h", 32'h0, IMEM_ARADDR);
      errors++;
    end
  endtask

  task automatic begin_test();
    @(posedge CLK);
    #2;
    fill_dmem();
    run_ref();
    budget_ns += (exp_count + 20) * 20;
    errors = 0;
    st_idx = 0;
    checking = 1'b1;
    apply_reset();
  endtask

  task automatic run_to_halt();
    int cycles;
    cycles = 0;
    while (!halted && cycles < exp_count + 20) begin
      @(posedge CLK);
      #1;
      cycles++;
    end
    assert (halted) else begin
      $display("halted never rose within %0d cycles", cycles);
      errors++;
    end
    assert (!halted || cycles == exp_count) else begin
      $display("mismatch cycles to halted: expected %h actual %h", exp_count, cycles);
      errors++;
    end
  endtask

  // PC frozen and no stores even though SW follows EBREAK
  task automatic check_halt();
    logic [31:0] held_pc;
    held_pc = IMEM_ARADDR;
    repeat (20) begin
      @(posedge CLK);
      #1;
      assert (IMEM_ARADDR == held_pc) else begin
        $display("mismatch IMEM_ARADDR while halted: expected %h actual %h",
                 held_pc, IMEM_ARADDR);
        errors++;
      end
      assert (!DMEM_AWVALID) else begin
        $display("store strobe high while halted");
        errors++;
      end
    end
  endtask

  task automatic finish_test(input string name);
    checking = 1'b0;
    assert (st_idx == exp_st.size()) else begin
      $display("wrong number of stores: %0d seen, %0d expected", st_idx, exp_st.size());
      errors++;
    end
    for (int i = 0; i < 256; i++) begin
      assert (dmem[i] === exp_mem[i]) else begin
        $display("mismatch dmem[%h]: expected %h actual %h", i * 4, exp_mem[i], dmem[i]);
        errors++;
      end
    end
    if (errors == 0) pass_cnt++;
    else fail_cnt++;
    $display("%-10s %s, %0d stores, %0d instructions, %0d errors", name,
             (errors == 0) ? "pass" : "fail", st_idx, exp_count, errors);
  endtask

  task automatic build_alu();
    new_program();
    emit(lui_op(5'd1, 32'h8000_0000));
    emit(alu_i(3'b000, 5'd1, 5'd1, 32'h123));
    emit(alu_i(3'b000, 5'd2, 5'd0, -5));
    load_const(5'd3, 32'h1234_5678);
    emit(alu_r(3'b000, 5'd4, 5'd1, 5'd3, 1'b0));
    emit(alu_r(3'b000, 5'd5, 5'd3, 5'd1, 1'b1));
    emit(alu_r(3'b111, 5'd6, 5'd1, 5'd2, 1'b0));
    emit(alu_r(3'b110, 5'd7, 5'd1, 5'd3, 1'b0));
    emit(alu_r(3'b100, 5'd8, 5'd2, 5'd3, 1'b0));
    // SLT with both operands negative, then mixed signs
    emit(alu_r(3'b010, 5'd9, 5'd1, 5'd2, 1'b0));
    emit(alu_r(3'b010, 5'd10, 5'd2, 5'd1, 1'b0));
    emit(alu_r(3'b010, 5'd11, 5'd2, 5'd3, 1'b0));
    emit(alu_i(3'b000, 5'd12, 5'd3, -2048));
    emit(alu_i(3'b111, 5'd13, 5'd3, 32'h7F0));
    emit(alu_i(3'b110, 5'd14, 5'd2, 32'h010));
    emit(alu_i(3'b100, 5'd15, 5'd1, -1));
    emit(alu_i(3'b010, 5'd16, 5'd2, -4));
    emit(alu_i(3'b010, 5'd17, 5'd2, -6));
    emit(alu_i(3'b010, 5'd18, 5'd3, -4));
    // Writes to x0 must vanish
    emit(alu_r(3'b000, 5'd0, 5'd3, 5'd1, 1'b0));
    emit(alu_i(3'b000, 5'd0, 5'd3, 5));
    for (int k = 4; k <= 18; k++) emit(sw_op(5'(k), 5'd0, 32'h100 + 4 * (k - 4)));
    emit(sw_op(5'd0, 5'd0, 32'h13C));
    emit(ebreak_op());
  endtask

  task automatic build_mem();
    logic [31:0] addr [4];
    new_program();
    emit(alu_i(3'b000, 5'd20, 5'd0, 32'h300));
    for (int k = 0; k < 4; k++) begin
      addr[k] = 32'h200 + ((next_rand() & 32'h3F) << 2);
      load_const(5'(5 + k), next_rand());
      emit(sw_op(5'(5 + k), 5'd0, addr[k]));
    end
    // Loads through a base register with negative offsets
    for (int k = 0; k < 4; k++) emit(lw_op(5'(10 + k), 5'd20, addr[k] - 32'h300));
    for (int k = 0; k < 4; k++) emit(sw_op(5'(10 + k), 5'd0, 32'h100 + 4 * k));
    emit(ebreak_op());
  endtask

  task automatic build_branch();
    new_program();
    emit(alu_i(3'b000, 5'd1, 5'd0, 5));
    emit(alu_i(3'b000, 5'd2, 5'd0, 32'h180));
    // Countdown loop with one store per pass
    emit(sw_op(5'd1, 5'd2, 0));
    emit(alu_i(3'b000, 5'd2, 5'd2, 4));
    emit(alu_i(3'b000, 5'd1, 5'd1, -1));
    emit(br_op(3'b001, 5'd1, 5'd0, -12));
    emit(br_op(3'b000, 5'd1, 5'd0, 8));
    emit(sw_op(5'd2, 5'd0, 32'h1F0));
    emit(jal_op(5'd3, 8));
    emit(sw_op(5'd2, 5'd0, 32'h1F4));
    emit(sw_op(5'd3, 5'd0, 32'h1F8));
    // BEQ not taken
    emit(br_op(3'b000, 5'd1, 5'd2, 8));
    emit(sw_op(5'd1, 5'd0, 32'h1FC));
    emit(ebreak_op());
  endtask

  task automatic build_halt();
    new_program();
    emit(alu_i(3'b000, 5'd1, 5'd0, 32'h55));
    emit(sw_op(5'd1, 5'd0, 32'h80));
    emit(ebreak_op());
    emit(sw_op(5'd1, 5'd0, 32'h84));
    emit(sw_op(5'd1, 5'd0, 32'h88));
  endtask

  task automatic build_random();
    logic [31:0] v;
    new_program();
    for (int n = 0; n < 39; n++) begin
      v = next_rand();
      case (v[1:0])
        2'd0: emit(alu_r(funct3_for(v[31:29]), v[8:4], v[13:9], v[18:14], v[31:29] == 3'd1));
        2'd1: emit(alu_i(funct3_for(v[31:29]), v[8:4], v[13:9], next_rand()));
        2'd2: emit(lui_op(v[8:4], next_rand()));
        default: emit(sw_op(v[18:14], 5'd0, 32'h300 + {v[27:22], 2'b00}));
      endcase
    end
    emit(ebreak_op());
  endtask

  initial begin
    rst_n = 1'b0;
    checking = 1'b0;
    rng = 32'd62315;
    pass_cnt = 0;
    fail_cnt = 0;
    errors = 0;
    st_idx = 0;
    budget_ns = 400;
    new_program();
    fill_dmem();

    build_alu();
    begin_test();
    run_to_halt();
    finish_test("alu");

    build_mem();
    begin_test();
    run_to_halt();
    finish_test("load_store");

    build_branch();
    begin_test();
    run_to_halt();
    finish_test("branch");

    build_halt();
    begin_test();
    run_to_halt();
    check_halt();
    finish_test("halt");

    // Reset lands mid-loop on a pending SW and the program reruns in full
    build_branch();
    begin_test();
    repeat (6) @(posedge CLK);
    #2;
    fill_dmem();
    st_idx = 0;
    apply_reset();
    run_to_halt();
    finish_test("reset");

    for (int n = 0; n < 5; n++) begin
      build_random();
      begin_test();
      run_to_halt();
      finish_test($sformatf("random_%0d", n));
    end

    $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // Deadline grows as each test's length becomes known
  initial begin
    #1;
    while ($time < budget_ns) begin
      #20;
    end
    $display("watchdog expired at %0t, the core stopped making progress", $time);
    $display("Test FAILED");
    $finish;
  end

endmodule

/* verilog/core.sv */
`timescale 1ns/1ps

module core (
  input  logic        CLK,
  input  logic        rst_n,
  // Data memory
  output logic [31:0] DMEM_ARADDR,
  input  logic [31:0] DMEM_RDATA,
  output logic [31:0] DMEM_AWADDR,
  output logic [31:0] DMEM_WDATA,
  output logic        DMEM_AWVALID,
  // Instruction memory
  output logic [31:0] IMEM_ARADDR,
  input  logic [31:0] IMEM_RDATA,
  output logic        halted
);

  // ALU
  core_pkg::alu_op_e              alu_op;
  logic [core_pkg::xlen-1:0]      alu_a, alu_b, alu_result;
  logic                           alu_zero;

  // Register file
  core_pkg::reg_wr_t              reg_wr;
  logic [core_pkg::reg_idx_w-1:0] rs1_idx, rs2_idx;
  logic [core_pkg::xlen-1:0]      rs1_data, rs2_data;

  // PC
  core_pkg::pc_sel_e              pc_sel;
  logic [core_pkg::xlen-1:0]      pc, pc_target;

  // Fetch straight from the PC register
  assign IMEM_ARADDR = pc;
  // Load and store share the ALU address
  assign DMEM_ARADDR = alu_result;
  assign DMEM_AWADDR = alu_result;

  control control_t (
    .CLK(CLK), .rst_n(rst_n),
    .instr(IMEM_RDATA), .pc(pc),
    .rs1_data(rs1_data), .rs2_data(rs2_data),
    .alu_result(alu_result), .alu_zero(alu_zero),
    .mem_rdata(DMEM_RDATA),
    .rs1_idx(rs1_idx), .rs2_idx(rs2_idx),
    .alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b),
    .reg_wr(reg_wr),
    .pc_sel(pc_sel), .pc_target(pc_target),
    .mem_we(DMEM_AWVALID), .mem_wdata(DMEM_WDATA),
    .halted(halted)
  );

  alu alu_t (
    .op(alu_op), .a(alu_a), .b(alu_b),
    .result(alu_result), .zero(alu_zero)
  );

  registers registers_t (
    .CLK(CLK), .rst_n(rst_n),
    .wr(reg_wr),
    .rd_idx1(rs1_idx), .rd_idx2(rs2_idx),
    .rd_data1(rs1_data), .rd_data2(rs2_data)
  );

  // HALT freezes the PC
  program_counter pc_t (
    .CLK(CLK), .rst_n(rst_n),
    .sel(pc_sel), .target(pc_target),
    .hold(halted), .pc(pc)
  );

endmodule

/* control/control.sv */
`timescale 1ns/1ps

module control (
  input  logic                               CLK,
  input  logic                               rst_n,
  input  logic [core_pkg::xlen-1:0]          instr,
  input  logic [core_pkg::xlen-1:0]          pc,
  input  logic [core_pkg::xlen-1:0]          rs1_data,
  input  logic [core_pkg::xlen-1:0]          rs2_data,
  input  logic [core_pkg::xlen-1:0]          alu_result,
  input  logic                               alu_zero,
  input  logic [core_pkg::xlen-1:0]          mem_rdata,
  output logic [core_pkg::reg_idx_w-1:0]     rs1_idx,
  output logic [core_pkg::reg_idx_w-1:0]     rs2_idx,
  output core_pkg::alu_op_e                  alu_op,
  output logic [core_pkg::xlen-1:0]          alu_a,
  output logic [core_pkg::xlen-1:0]          alu_b,
  output core_pkg::reg_wr_t                  reg_wr,
  output core_pkg::pc_sel_e                  pc_sel,
  output logic [core_pkg::xlen-1:0]          pc_target,
  output logic                               mem_we,
  output logic [core_pkg::xlen-1:0]          mem_wdata,
  output logic                               halted
);

  typedef enum logic {st_run, st_halt} state_e;

  state_e                         state;
  core_pkg::ctrl_t                ctrl;
  core_pkg::alu_op_e              f3_op;
  logic                           f3_ok;
  logic                           r_legal;
  logic                           is_ebreak;
  logic                           taken;
  logic [6:0]                     opcode;
  logic [2:0]                     funct3;
  logic [core_pkg::reg_idx_w-1:0] rd_idx;
  logic [core_pkg::xlen-1:0]      imm_i, imm_s, imm_b, imm_u, imm_j;

  // Instruction fields
  assign opcode  = instr[6:0];
  assign rd_idx  = instr[11:7];
  assign funct3  = instr[14:12];
  assign rs1_idx = instr[19:15];
  assign rs2_idx = instr[24:20];

  // Sign extended immediates per format
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // funct3 to ALU op for both OP and OP-IMM
  always_comb begin
    f3_ok = 1'b1;
    case (funct3)
      core_pkg::f3_add_sub: f3_op = core_pkg::alu_add;
      core_pkg::f3_slt:     f3_op = core_pkg::alu_slt;
      core_pkg::f3_xor:     f3_op = core_pkg::alu_xor;
      core_pkg::f3_or:      f3_op = core_pkg::alu_or;
      core_pkg::f3_and:     f3_op = core_pkg::alu_and;
      // Shifts and SLTU lie outside the subset
      default: begin
        f3_op = core_pkg::alu_add;
        f3_ok = 1'b0;
      end
    endcase
  end

  // funct7 must be 0 or 0100000 with SUB
  assign r_legal = (instr[31:25] == 7'b0) ||
                   (instr[31:25] == 7'b0100000 && funct3 == core_pkg::f3_add_sub);

  // Main decoder with unknown opcodes as no-ops
  always_comb begin
    ctrl.alu_op  = core_pkg::alu_add;
    ctrl.use_imm = 1'b0;
    ctrl.reg_we  = 1'b0;
    ctrl.wb_sel  = core_pkg::wb_alu;
    ctrl.mem_we  = 1'b0;
    ctrl.imm     = imm_i;
    ctrl.pc_sel  = core_pkg::pc_seq;
    is_ebreak    = 1'b0;
    case (opcode)
      core_pkg::op_op: begin
        ctrl.alu_op = instr[30] ? core_pkg::alu_sub : f3_op;
        ctrl.reg_we = f3_ok && r_legal;
      end
      core_pkg::op_op_imm: begin
        ctrl.alu_op  = f3_op;
        ctrl.use_imm = 1'b1;
        ctrl.reg_we  = f3_ok;
      end
      core_pkg::op_lui: begin
        ctrl.alu_op  = core_pkg::alu_pass_b;
        ctrl.use_imm = 1'b1;
        ctrl.imm     = imm_u;
        ctrl.reg_we  = 1'b1;
      end
      core_pkg::op_load: begin
        // Address is rs1 + I immediate
        ctrl.use_imm = 1'b1;
        ctrl.reg_we  = (funct3 == core_pkg::f3_word);
        ctrl.wb_sel  = core_pkg::wb_mem;
      end
      core_pkg::op_store: begin
        ctrl.use_imm = 1'b1;
        ctrl.imm     = imm_s;
        ctrl.mem_we  = (funct3 == core_pkg::f3_word);
      end
      core_pkg::op_branch: begin
        // SUB drives the zero flag for the compare
        ctrl.alu_op = core_pkg::alu_sub;
        ctrl.imm    = imm_b;
        if (funct3 == core_pkg::f3_beq || funct3 == core_pkg::f3_bne) begin
          ctrl.pc_sel = core_pkg::pc_branch;
        end
      end
      core_pkg::op_jal: begin
        ctrl.imm    = imm_j;
        ctrl.reg_we = 1'b1;
        ctrl.wb_sel = core_pkg::wb_pc4;
        ctrl.pc_sel = core_pkg::pc_jump;
      end
      core_pkg::op_system: is_ebreak = (instr == core_pkg::instr_ebreak);
      default: ;
    endcase
  end

  // Operand muxes
  assign alu_op = ctrl.alu_op;
  assign alu_a  = rs1_data;
  assign alu_b  = ctrl.use_imm ? ctrl.imm : rs2_data;

  // BEQ takes on zero and BNE on nonzero
  assign taken  = (funct3 == core_pkg::f3_bne) ? !alu_zero : alu_zero;
  assign pc_sel = (ctrl.pc_sel == core_pkg::pc_branch && !taken) ? core_pkg::pc_seq
                                                                   : ctrl.pc_sel;
  assign pc_target = pc + ctrl.imm;

  // Writeback with x0 writes dropped here
  assign reg_wr.we  = ctrl.reg_we && (rd_idx != '0) && (state == st_run);
  assign reg_wr.idx = rd_idx;
  always_comb begin
    case (ctrl.wb_sel)
      core_pkg::wb_mem: reg_wr.data = mem_rdata;
      core_pkg::wb_pc4: reg_wr.data = pc + 32'd4;
      default:          reg_wr.data = alu_result;
    endcase
  end

  // Store strobe stays quiet during reset too
  assign mem_we    = ctrl.mem_we && (state == st_run) && rst_n;
  assign mem_wdata = rs2_data;

  // RUN until EBREAK retires, then HALT until reset
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state <= st_run;
    end else if (state == st_run && is_ebreak) begin
      state <= st_halt;
    end
  end

  assign halted = (state == st_halt);

endmodule

/* verilog/program_counter.sv */
`timescale 1ns/1ps

module program_counter (
  input  logic                          CLK,
  input  logic                          rst_n,
  input  core_pkg::pc_sel_e             sel,
  input  logic [core_pkg::xlen-1:0]     target,
  input  logic                          hold,
  output logic [core_pkg::xlen-1:0]     pc
);

  logic [core_pkg::xlen-1:0] pc_next;

  // Next PC select
  always_comb begin
    case (sel)
      core_pkg::pc_seq:    pc_next = pc + 32'd4;
      // Only taken branches reach here
      core_pkg::pc_branch: pc_next = target;
      core_pkg::pc_jump:   pc_next = target;
      default:             pc_next = pc + 32'd4;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      pc <= core_pkg::reset_pc;
    end else if (!hold) begin
      pc <= pc_next;
    end
  end

  // Fetch address stays word aligned
  a_pc_aligned: assert property (
    @(posedge CLK) disable iff (!rst_n)
    pc[1:0] == 2'b00
  ) else $error("program_counter: misaligned PC %h", pc);

endmodule

/* verilog/registers.sv */
`timescale 1ns/1ps

module registers (
  input  logic                               CLK,
  input  logic                               rst_n,
  input  core_pkg::reg_wr_t                  wr,
  input  logic [core_pkg::reg_idx_w-1:0]     rd_idx1,
  input  logic [core_pkg::reg_idx_w-1:0]     rd_idx2,
  output logic [core_pkg::xlen-1:0]          rd_data1,
  output logic [core_pkg::xlen-1:0]          rd_data2
);

  // x1..x31 only, x0 has no storage
  logic [31:1][core_pkg::xlen-1:0] regs;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      regs <= '0;
    end else if (wr.we && (wr.idx != '0)) begin
      regs[wr.idx] <= wr.data;
    end
  end

  // Combinational reads, old value during a same-cycle write
  assign rd_data1 = (rd_idx1 == '0) ? '0 : regs[rd_idx1];
  assign rd_data2 = (rd_idx2 == '0) ? '0 : regs[rd_idx2];

  // Every architectural register holds a known value out of reset
  a_no_x_regs: assert property (
    @(posedge CLK) disable iff (!rst_n)
    !$isunknown(regs)
  ) else $error("registers: X found in register file");

endmodule

/* verilog/alu.sv */
`timescale 1ns/1ps

module alu (
  input  core_pkg::alu_op_e             op,
  input  logic [core_pkg::xlen-1:0]     a,
  input  logic [core_pkg::xlen-1:0]     b,
  output logic [core_pkg::xlen-1:0]     result,
  output logic                          zero
);

  logic slt;

  // Signed compare for SLT / SLTI
  assign slt = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      core_pkg::alu_add: result = a + b;
      core_pkg::alu_sub: result = a - b;
      core_pkg::alu_and: result = a & b;
      core_pkg::alu_or:  result = a | b;
      core_pkg::alu_xor: result = a ^ b;
      // Zero extended compare bit
      core_pkg::alu_slt: result = {{(core_pkg::xlen-1){1'b0}}, slt};
      // LUI passes the U immediate
      core_pkg::alu_pass_b: result = b;
      default: result = '0;
    endcase
  end

  // Branch compare flag, SUB result equal to zero
  assign zero = (result == '0);

endmodule

/* common/core_pkg.sv */
package core_pkg;

  // Datapath and register index widths
  localparam int xlen = 32;
  localparam int reg_idx_w = 5;

  // First fetch address out of reset
  localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

  // RV32I major opcodes of the supported subset
  localparam logic [6:0] op_op     = 7'b0110011;
  localparam logic [6:0] op_op_imm = 7'b0010011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_system = 7'b1110011;

  // funct3 codes
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;
  localparam logic [2:0] f3_beq     = 3'b000;
  localparam logic [2:0] f3_bne     = 3'b001;
  // LW / SW width field
  localparam logic [2:0] f3_word    = 3'b010;

  // EBREAK is a single fixed encoding
  localparam logic [31:0] instr_ebreak = 32'h0010_0073;

  // Writeback source select
  localparam logic [1:0] wb_alu = 2'd0;
  localparam logic [1:0] wb_mem = 2'd1;
  localparam logic [1:0] wb_pc4 = 2'd2;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_pass_b
  } alu_op_e;

  typedef enum logic [1:0] {
    pc_seq,
    pc_branch,
    pc_jump
  } pc_sel_e;

  // Decoded control for one instruction
  typedef struct packed {
    alu_op_e         alu_op;
    logic            use_imm;
    logic            reg_we;
    logic [1:0]      wb_sel;
    logic            mem_we;
    logic [xlen-1:0] imm;
    pc_sel_e         pc_sel;
  } ctrl_t;

  // Register file write request
  typedef struct packed {
    logic                 we;
    logic [reg_idx_w-1:0] idx;
    logic [xlen-1:0]      data;
  } reg_wr_t;

endpackage
